// File: design/coreTypes.sv
package coreTypes;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;
    typedef logic [6:0]  opcodeT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluPassB                   // lui result is operand b.
    } aluFuncT;

    typedef enum logic [2:0] {
        opAlu,
        opLoad,
        opStore,
        opBranchEq,
        opBranchNe,
        opNone                     // illegal, writes nothing.
    } opKindT;

    typedef enum logic {
        memIdle,
        memWait
    } memStateT;

    localparam wordT resetPc = 32'h0000_0000;

    localparam opcodeT opcOp     = 7'b0110011;
    localparam opcodeT opcOpImm  = 7'b0010011;
    localparam opcodeT opcLui    = 7'b0110111;
    localparam opcodeT opcLoad   = 7'b0000011;
    localparam opcodeT opcStore  = 7'b0100011;
    localparam opcodeT opcBranch = 7'b1100011;

endpackage

// File: design/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
    input  logic            clk,
    input  logic            rstN,
    input  logic            stall,
    input  logic            redirect,
    input  coreTypes::wordT redirectPc,
    output coreTypes::wordT imemAddr,
    input  coreTypes::wordT imemData,
    output logic            fetchValid,
    output coreTypes::wordT fetchPc,
    output coreTypes::wordT fetchInstr
);

    coreTypes::wordT pc;

    assign imemAddr = pc;           // combinational imem read.

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc         <= coreTypes::resetPc;
            fetchValid <= 1'b0;
        end else if (redirect) begin
            pc         <= redirectPc;
            fetchValid <= 1'b0;     // wrong-path fetch dropped.
        end else if (!stall) begin
            pc         <= pc + 32'd4;
            fetchValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !redirect) begin
            fetchPc    <= pc;
            fetchInstr <= imemData;
        end
    end

endmodule

// File: design/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  coreTypes::wordT    instr,
    output coreTypes::opKindT  kind,
    output coreTypes::aluFuncT func,
    output logic               regWrite,
    output logic               useRs1,
    output logic               useRs2
);

    coreTypes::opcodeT opcode;
    logic [2:0]        funct3;
    logic              writes;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        kind   = coreTypes::opNone;
        func   = coreTypes::aluAdd;
        writes = 1'b0;
        useRs1 = 1'b0;
        useRs2 = 1'b0;
        case (opcode)
            coreTypes::opcOp, coreTypes::opcOpImm: begin
                kind   = coreTypes::opAlu;
                writes = 1'b1;
                useRs1 = 1'b1;
                useRs2 = (opcode == coreTypes::opcOp);
                case (funct3)
                    3'b000: begin
                        // sub only exists in the register form.
                        if (opcode == coreTypes::opcOp && instr[30])
                            func = coreTypes::aluSub;
                    end
                    3'b111: func = coreTypes::aluAnd;
                    3'b110: func = coreTypes::aluOr;
                    3'b100: func = coreTypes::aluXor;
                    3'b010: func = (opcode == coreTypes::opcOp) ? coreTypes::aluSlt
                                                                : coreTypes::aluAdd;
                    default: begin
                        kind   = coreTypes::opNone;
                        writes = 1'b0;
                    end
                endcase
                if (opcode == coreTypes::opcOpImm && funct3 == 3'b010) begin
                    kind   = coreTypes::opNone;   // slti not covered.
                    writes = 1'b0;
                end
            end
            coreTypes::opcLui: begin
                kind   = coreTypes::opAlu;
                func   = coreTypes::aluPassB;
                writes = 1'b1;
            end
            coreTypes::opcLoad: begin
                if (funct3 == 3'b010) begin
                    kind   = coreTypes::opLoad;
                    writes = 1'b1;
                    useRs1 = 1'b1;
                end
            end
            coreTypes::opcStore: begin
                if (funct3 == 3'b010) begin
                    kind   = coreTypes::opStore;
                    useRs1 = 1'b1;
                    useRs2 = 1'b1;
                end
            end
            coreTypes::opcBranch: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                if (funct3 == 3'b000)
                    kind = coreTypes::opBranchEq;
                else if (funct3 == 3'b001)
                    kind = coreTypes::opBranchNe;
            end
            default: ;
        endcase
    end

    assign regWrite = writes && (instr[11:7] != 5'd0);  // x0 never written.

endmodule

// File: design/immSelect.sv
`timescale 1ns/1ps

module immSelect (
    input  coreTypes::wordT   instr,
    input  coreTypes::wordT   pc,
    input  coreTypes::opKindT kind,
    input  coreTypes::wordT   src1,
    input  coreTypes::wordT   src2,
    input  logic              useRs1,
    input  logic              useRs2,
    input  logic              hazard1,
    input  logic              hazard2,
    output coreTypes::wordT   opA,
    output coreTypes::wordT   opB,
    output coreTypes::wordT   storeData,
    output logic              bubble
);

    coreTypes::wordT immI;
    coreTypes::wordT immS;
    coreTypes::wordT immB;
    coreTypes::wordT immU;
    coreTypes::wordT imm;
    logic            isBranch;

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'h000};

    assign isBranch = (kind == coreTypes::opBranchEq) || (kind == coreTypes::opBranchNe);

    always_comb begin
        if (kind == coreTypes::opStore)
            imm = immS;
        else if (instr[6:0] == coreTypes::opcLui)
            imm = immU;
        else
            imm = immI;
    end

    assign opA = src1;
    assign opB = (useRs2 && kind != coreTypes::opStore) ? src2 : imm;

    // branches carry their target in the store slot.
    assign storeData = isBranch ? pc + immB : src2;

    assign bubble = (useRs1 && hazard1) || (useRs2 && hazard2);

endmodule

// File: design/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic               clk,
    input  logic               rstN,
    input  logic               stall,
    input  logic               flush,
    input  logic               fetchValid,
    input  coreTypes::wordT    fetchPc,
    input  coreTypes::wordT    fetchInstr,
    output coreTypes::regIdxT  rs1,
    output coreTypes::regIdxT  rs2,
    input  coreTypes::wordT    rdata1,
    input  coreTypes::wordT    rdata2,
    input  coreTypes::regIdxT  exDst,
    input  logic               exRegWrite,
    input  logic               exIsLoad,
    input  coreTypes::wordT    exResult,
    input  coreTypes::regIdxT  memDst,
    input  logic               memRegWrite,
    input  coreTypes::wordT    memResult,
    output logic               decStall,
    output logic               decValid,
    output coreTypes::wordT    decPc,
    output coreTypes::opKindT  decKind,
    output coreTypes::aluFuncT decFunc,
    output coreTypes::regIdxT  decDst,
    output logic               decRegWrite,
    output coreTypes::wordT    decOpA,
    output coreTypes::wordT    decOpB,
    output coreTypes::wordT    decStoreData,
    output coreTypes::wordT    decBranchTarget
);

    coreTypes::opKindT  kind;
    coreTypes::aluFuncT func;
    logic               regWrite;
    logic               useRs1;
    logic               useRs2;
    coreTypes::wordT    src1;
    coreTypes::wordT    src2;
    logic               hazard1;
    logic               hazard2;
    coreTypes::wordT    opA;
    coreTypes::wordT    opB;
    coreTypes::wordT    storeData;
    logic               needBubble;

    function automatic coreTypes::wordT forward(coreTypes::regIdxT rs, coreTypes::wordT rdata);
        if (rs != 5'd0 && exRegWrite && rs == exDst)
            return exResult;
        if (rs != 5'd0 && memRegWrite && rs == memDst)
            return memResult;
        return rdata;
    endfunction

    // the entry now in execute has no result yet, and a load in memory
    // has no data before its access ends.
    function automatic logic hazardOn(coreTypes::regIdxT rs);
        return rs != 5'd0 && ((decValid && decRegWrite && rs == decDst) ||
                              (exRegWrite && exIsLoad && rs == exDst));
    endfunction

    assign rs1 = fetchInstr[19:15];
    assign rs2 = fetchInstr[24:20];

    always_comb begin
        src1    = forward(rs1, rdata1);
        src2    = forward(rs2, rdata2);
        hazard1 = hazardOn(rs1);
        hazard2 = hazardOn(rs2);
    end

    instrDecoder decoder (
        .instr    (fetchInstr),
        .kind     (kind),
        .func     (func),
        .regWrite (regWrite),
        .useRs1   (useRs1),
        .useRs2   (useRs2)
    );

    immSelect operands (
        .instr     (fetchInstr),
        .pc        (fetchPc),
        .kind      (kind),
        .src1      (src1),
        .src2      (src2),
        .useRs1    (useRs1),
        .useRs2    (useRs2),
        .hazard1   (hazard1),
        .hazard2   (hazard2),
        .opA       (opA),
        .opB       (opB),
        .storeData (storeData),
        .bubble    (needBubble)
    );

    assign decStall        = fetchValid && needBubble;
    assign decBranchTarget = decStoreData;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid    <= 1'b0;
            decKind     <= coreTypes::opNone;
            decRegWrite <= 1'b0;
        end else if (!stall) begin
            decValid    <= fetchValid && !flush && !needBubble;
            decKind     <= kind;
            decRegWrite <= regWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            decPc        <= fetchPc;
            decFunc      <= func;
            decDst       <= fetchInstr[11:7];
            decOpA       <= opA;
            decOpB       <= opB;
            decStoreData <= storeData;
        end
    end

endmodule

// File: design/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic              clk,
    input  logic              rstN,
    input  coreTypes::regIdxT rs1,
    input  coreTypes::regIdxT rs2,
    output coreTypes::wordT   rdata1,
    output coreTypes::wordT   rdata2,
    input  logic              we,
    input  coreTypes::regIdxT wd,
    input  coreTypes::wordT   wdata
);

    coreTypes::wordT regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && wd != 5'd0) begin
            regs[wd] <= wdata;
        end
    end

    // same-cycle write goes straight to the reader.
    assign rdata1 = (rs1 == 5'd0) ? '0 : (we && wd == rs1) ? wdata : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : (we && wd == rs2) ? wdata : regs[rs2];

endmodule

// File: design/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic               clk,
    input  logic               rstN,
    input  logic               stall,
    input  logic               decValid,
    input  coreTypes::opKindT  decKind,
    input  coreTypes::aluFuncT decFunc,
    input  coreTypes::regIdxT  decDst,
    input  logic               decRegWrite,
    input  coreTypes::wordT    decOpA,
    input  coreTypes::wordT    decOpB,
    input  coreTypes::wordT    decStoreData,
    input  coreTypes::wordT    decBranchTarget,
    output coreTypes::regIdxT  exDst,
    output logic               exRegWrite,
    output logic               exIsLoad,
    output coreTypes::wordT    exResult,
    output coreTypes::opKindT  exKind,
    output coreTypes::wordT    exStoreData,
    output logic               exValid,
    output logic               branchTaken,
    output coreTypes::wordT    branchTarget
);

    coreTypes::wordT aluOut;
    logic            operandsEqual;

    always_comb begin
        case (decFunc)
            coreTypes::aluSub:   aluOut = decOpA - decOpB;
            coreTypes::aluAnd:   aluOut = decOpA & decOpB;
            coreTypes::aluOr:    aluOut = decOpA | decOpB;
            coreTypes::aluXor:   aluOut = decOpA ^ decOpB;
            coreTypes::aluSlt:   aluOut = {31'd0, $signed(decOpA) < $signed(decOpB)};
            coreTypes::aluPassB: aluOut = decOpB;
            default:             aluOut = decOpA + decOpB;
        endcase
    end

    assign operandsEqual = (decOpA == decOpB);
    assign branchTaken   = decValid &&
                           ((decKind == coreTypes::opBranchEq && operandsEqual) ||
                            (decKind == coreTypes::opBranchNe && !operandsEqual));
    assign branchTarget  = decBranchTarget;

    assign exIsLoad = exValid && (exKind == coreTypes::opLoad);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exValid    <= 1'b0;
            exRegWrite <= 1'b0;
            exKind     <= coreTypes::opNone;
        end else if (!stall) begin
            exValid    <= decValid;
            exRegWrite <= decValid && decRegWrite;
            exKind     <= decKind;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            exDst       <= decDst;
            exResult    <= aluOut;
            exStoreData <= decStoreData;
        end
    end

endmodule

// File: design/memStage.sv
`timescale 1ns/1ps

module memStage #(
    parameter int MemLatency = 2,
    parameter int DmemWords  = 64
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              exValid,
    input  coreTypes::opKindT exKind,
    input  coreTypes::regIdxT exDst,
    input  logic              exRegWrite,
    input  coreTypes::wordT   exResult,
    input  coreTypes::wordT   exStoreData,
    output logic              memStall,
    output coreTypes::regIdxT memDst,
    output logic              memRegWrite,
    output coreTypes::wordT   memResult,
    output logic              wbValid,
    output coreTypes::regIdxT wbDst,
    output coreTypes::wordT   wbData
);

    localparam int CntW  = $clog2(MemLatency + 1);
    localparam int AddrW = $clog2(DmemWords);

    coreTypes::memStateT state;
    logic [CntW-1:0]     waitCnt;
    logic                isMem;
    logic                accessDone;
    logic                fire;
    coreTypes::wordT     wordIdx;
    logic [AddrW-1:0]    dmemIdx;
    coreTypes::wordT     dmem [DmemWords];

    assign isMem      = exValid && (exKind == coreTypes::opLoad || exKind == coreTypes::opStore);
    assign accessDone = (state == coreTypes::memWait) && (waitCnt == '0);
    assign memStall   = isMem && !accessDone;
    assign fire       = exValid && (!isMem || accessDone);   // entry leaves this cycle.

    assign wordIdx = (exResult >> 2) % DmemWords;
    assign dmemIdx = wordIdx[AddrW-1:0];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= coreTypes::memIdle;
            waitCnt <= '0;
        end else if (state == coreTypes::memIdle) begin
            if (isMem) begin
                state   <= coreTypes::memWait;
                waitCnt <= CntW'(MemLatency - 1);
            end
        end else if (waitCnt == '0) begin
            state <= coreTypes::memIdle;
        end else begin
            waitCnt <= waitCnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < DmemWords; i++)
                dmem[i] <= '0;
            wbValid <= 1'b0;
        end else begin
            wbValid <= fire && exRegWrite;
            if (fire && exKind == coreTypes::opStore)
                dmem[dmemIdx] <= exStoreData;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            wbDst  <= exDst;
            wbData <= (exKind == coreTypes::opLoad) ? dmem[dmemIdx] : exResult;
        end
    end

    // the writeback entry doubles as the oldest forwarding source.
    assign memDst      = wbDst;
    assign memRegWrite = wbValid;
    assign memResult   = wbData;

endmodule

// File: design/coreTop.sv
`timescale 1ns/1ps

module coreTop #(
    parameter int MemLatency = 2,
    parameter int DmemWords  = 64
) (
    input  logic              clk,
    input  logic              rstN,
    output coreTypes::wordT   imemAddr,
    input  coreTypes::wordT   imemData,
    output logic              wbValid,
    output coreTypes::regIdxT wbDst,
    output coreTypes::wordT   wbData
);

    logic               fetchValid;
    coreTypes::wordT    fetchPc;
    coreTypes::wordT    fetchInstr;
    coreTypes::regIdxT  rs1;
    coreTypes::regIdxT  rs2;
    coreTypes::wordT    rdata1;
    coreTypes::wordT    rdata2;
    logic               decStall;
    logic               decValid;
    coreTypes::opKindT  decKind;
    coreTypes::aluFuncT decFunc;
    coreTypes::regIdxT  decDst;
    logic               decRegWrite;
    coreTypes::wordT    decOpA;
    coreTypes::wordT    decOpB;
    coreTypes::wordT    decStoreData;
    coreTypes::wordT    decBranchTarget;
    coreTypes::regIdxT  exDst;
    logic               exRegWrite;
    logic               exIsLoad;
    coreTypes::wordT    exResult;
    coreTypes::opKindT  exKind;
    coreTypes::wordT    exStoreData;
    logic               exValid;
    logic               branchTaken;
    coreTypes::wordT    branchTarget;
    logic               memStall;
    coreTypes::regIdxT  memDst;
    logic               memRegWrite;
    coreTypes::wordT    memResult;
    logic               redirect;

    assign redirect = branchTaken && !memStall;   // memory stall wins.

    fetchStage fetch (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (decStall || memStall),
        .redirect   (redirect),
        .redirectPc (branchTarget),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .fetchInstr (fetchInstr)
    );

    decodeStage decode (
        .clk             (clk),
        .rstN            (rstN),
        .stall           (memStall),
        .flush           (redirect),
        .fetchValid      (fetchValid),
        .fetchPc         (fetchPc),
        .fetchInstr      (fetchInstr),
        .rs1             (rs1),
        .rs2             (rs2),
        .rdata1          (rdata1),
        .rdata2          (rdata2),
        .exDst           (exDst),
        .exRegWrite      (exRegWrite),
        .exIsLoad        (exIsLoad),
        .exResult        (exResult),
        .memDst          (memDst),
        .memRegWrite     (memRegWrite),
        .memResult       (memResult),
        .decStall        (decStall),
        .decValid        (decValid),
        .decPc           (),
        .decKind         (decKind),
        .decFunc         (decFunc),
        .decDst          (decDst),
        .decRegWrite     (decRegWrite),
        .decOpA          (decOpA),
        .decOpB          (decOpB),
        .decStoreData    (decStoreData),
        .decBranchTarget (decBranchTarget)
    );

    regFile regs (
        .clk    (clk),
        .rstN   (rstN),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (wbValid),
        .wd     (wbDst),
        .wdata  (wbData)
    );

    executeStage execute (
        .clk             (clk),
        .rstN            (rstN),
        .stall           (memStall),
        .decValid        (decValid),
        .decKind         (decKind),
        .decFunc         (decFunc),
        .decDst          (decDst),
        .decRegWrite     (decRegWrite),
        .decOpA          (decOpA),
        .decOpB          (decOpB),
        .decStoreData    (decStoreData),
        .decBranchTarget (decBranchTarget),
        .exDst           (exDst),
        .exRegWrite      (exRegWrite),
        .exIsLoad        (exIsLoad),
        .exResult        (exResult),
        .exKind          (exKind),
        .exStoreData     (exStoreData),
        .exValid         (exValid),
        .branchTaken     (branchTaken),
        .branchTarget    (branchTarget)
    );

    memStage #(
        .MemLatency (MemLatency),
        .DmemWords  (DmemWords)
    ) memory (
        .clk         (clk),
        .rstN        (rstN),
        .exValid     (exValid),
        .exKind      (exKind),
        .exDst       (exDst),
        .exRegWrite  (exRegWrite),
        .exResult    (exResult),
        .exStoreData (exStoreData),
        .memStall    (memStall),
        .memDst      (memDst),
        .memRegWrite (memRegWrite),
        .memResult   (memResult),
        .wbValid     (wbValid),
        .wbDst       (wbDst),
        .wbData      (wbData)
    );

endmodule

// File: tests/coreTopTb.sv
`timescale 1ns/1ps

module coreTopTb;

    localparam int NumTests   = 5;
    localparam int Slots      = 8;
    localparam int MaxWrites  = 8;
    localparam int TestCycles = Slots * 12;
    localparam int CycleLimit = NumTests * (Slots * 12 + 20);
    localparam coreTypes::wordT Nop = 32'h0000_0013;   // addi x0, x0, 0.

    logic              clk;
    logic              rstN;
    coreTypes::wordT   imemAddr;
    coreTypes::wordT   imemData;
    logic              wbValid;
    coreTypes::regIdxT wbDst;
    coreTypes::wordT   wbData;

    coreTypes::wordT   imem [Slots];
    string             testName [NumTests];
    coreTypes::wordT   prog [NumTests][Slots];
    coreTypes::regIdxT expDst [NumTests][MaxWrites];
    coreTypes::wordT   expVal [NumTests][MaxWrites];
    int                expCount [NumTests];
    int                errorCount;
    int                failedTests;
    int                cycleCount = 0;
    integer            seed;

    coreTop #(
        .MemLatency (2)
    ) UUT (
        .clk      (clk),
        .rstN     (rstN),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .wbValid  (wbValid),
        .wbDst    (wbDst),
        .wbData   (wbData)
    );

    // past the program the core only sees nops.
    assign imemData = (imemAddr < Slots * 4) ? imem[imemAddr[4:2]] : Nop;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("timeout after %0d cycles, the core stopped writing back", cycleCount);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic coreTypes::wordT opReg(input logic [6:0] f7, input logic [2:0] f3,
                                              input coreTypes::regIdxT rd,
                                              input coreTypes::regIdxT rs1,
                                              input coreTypes::regIdxT rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic coreTypes::wordT opImm(input logic [2:0] f3, input coreTypes::regIdxT rd,
                                              input coreTypes::regIdxT rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic coreTypes::wordT lui(input coreTypes::regIdxT rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic coreTypes::wordT lw(input coreTypes::regIdxT rd,
                                           input coreTypes::regIdxT rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic coreTypes::wordT sw(input coreTypes::regIdxT rs2,
                                           input coreTypes::regIdxT rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic coreTypes::wordT branch(input logic [2:0] f3,
                                               input coreTypes::regIdxT rs1,
                                               input coreTypes::regIdxT rs2,
                                               input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic addWrite(input int t, input coreTypes::regIdxT dst, input coreTypes::wordT val);
        expDst[t][expCount[t]] = dst;
        expVal[t][expCount[t]] = val;
        expCount[t]++;
    endtask

    task automatic buildTable;
        logic [31:0]     rnd;
        logic [11:0]     imm;
        coreTypes::wordT a;
        coreTypes::wordT b;
        for (int t = 0; t < NumTests; t++) begin
            expCount[t] = 0;
            for (int i = 0; i < Slots; i++)
                prog[t][i] = Nop;
        end
        rnd = $random(seed);
        imm = rnd[11:0];
        a   = {{20{imm[11]}}, imm};
        b   = 32'h8001_2000;

        testName[0] = "aluOps";
        prog[0][0] = opImm(3'b000, 1, 0, imm);
        prog[0][1] = lui(2, 20'h80012);
        prog[0][2] = opReg(7'b0000000, 3'b000, 3, 1, 2);
        prog[0][3] = opReg(7'b0100000, 3'b000, 4, 1, 2);
        prog[0][4] = opReg(7'b0000000, 3'b111, 5, 1, 2);
        prog[0][5] = opReg(7'b0000000, 3'b110, 6, 1, 2);
        prog[0][6] = opReg(7'b0000000, 3'b100, 7, 1, 2);
        prog[0][7] = opReg(7'b0000000, 3'b010, 8, 2, 1);
        addWrite(0, 1, a);
        addWrite(0, 2, b);
        addWrite(0, 3, a + b);
        addWrite(0, 4, a - b);
        addWrite(0, 5, a & b);
        addWrite(0, 6, a | b);
        addWrite(0, 7, a ^ b);
        addWrite(0, 8, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);

        testName[1] = "depChain";
        prog[1][0] = opImm(3'b000, 1, 0, 12'd5);
        prog[1][1] = opImm(3'b000, 1, 1, 12'd7);
        prog[1][2] = opImm(3'b100, 2, 1, 12'h0F0);
        prog[1][3] = opImm(3'b110, 3, 2, 12'h001);
        prog[1][4] = opImm(3'b111, 4, 3, 12'h0F5);
        prog[1][5] = opImm(3'b000, 0, 4, 12'd99);          // x0 must stay zero.
        prog[1][6] = opReg(7'b0000000, 3'b000, 5, 0, 4);
        prog[1][7] = opReg(7'b0100000, 3'b000, 6, 4, 1);
        addWrite(1, 1, 32'd5);
        addWrite(1, 1, 32'd5 + 32'd7);
        addWrite(1, 2, (32'd5 + 32'd7) ^ 32'h0F0);
        addWrite(1, 3, ((32'd5 + 32'd7) ^ 32'h0F0) | 32'h001);
        addWrite(1, 4, (((32'd5 + 32'd7) ^ 32'h0F0) | 32'h001) & 32'h0F5);
        addWrite(1, 5, expVal[1][4]);
        addWrite(1, 6, expVal[1][4] - expVal[1][1]);

        testName[2] = "loadStore";
        prog[2][0] = lui(1, 20'h12345);
        prog[2][1] = opImm(3'b000, 1, 1, 12'h678);
        prog[2][2] = opImm(3'b000, 2, 0, 12'h040);
        prog[2][3] = sw(1, 2, 12'd8);
        prog[2][4] = lw(3, 2, 12'd8);
        prog[2][5] = opReg(7'b0000000, 3'b000, 4, 3, 1);    // load-use.
        prog[2][6] = lw(5, 0, 12'h048);                      // same word, absolute.
        prog[2][7] = opReg(7'b0100000, 3'b000, 6, 5, 4);
        addWrite(2, 1, 32'h1234_5000);
        addWrite(2, 1, 32'h1234_5678);
        addWrite(2, 2, 32'h0000_0040);
        addWrite(2, 3, 32'h1234_5678);
        addWrite(2, 4, 32'h1234_5678 + 32'h1234_5678);
        addWrite(2, 5, 32'h1234_5678);
        addWrite(2, 6, 32'h1234_5678 - (32'h1234_5678 + 32'h1234_5678));

        testName[3] = "branchTaken";
        prog[3][0] = opImm(3'b000, 1, 0, 12'd3);
        prog[3][1] = opImm(3'b000, 2, 0, 12'd3);
        prog[3][2] = branch(3'b000, 1, 2, 13'd12);           // beq to slot 5.
        prog[3][3] = opImm(3'b000, 3, 0, 12'd1);
        prog[3][4] = opImm(3'b000, 4, 0, 12'd2);
        prog[3][5] = opImm(3'b000, 5, 0, 12'd7);
        prog[3][6] = opReg(7'b0000000, 3'b000, 6, 5, 1);
        addWrite(3, 1, 32'd3);
        addWrite(3, 2, 32'd3);
        addWrite(3, 5, 32'd7);
        addWrite(3, 6, 32'd10);

        testName[4] = "branchNotTaken";
        prog[4][0] = opImm(3'b000, 1, 0, 12'd4);
        prog[4][1] = opImm(3'b000, 2, 0, 12'd4);
        prog[4][2] = branch(3'b001, 1, 2, 13'd16);           // bne, operands equal.
        prog[4][3] = opImm(3'b000, 3, 0, 12'd11);
        prog[4][4] = opReg(7'b0000000, 3'b000, 4, 3, 1);
        prog[4][5] = opReg(7'b0100000, 3'b000, 5, 4, 2);
        prog[4][6] = opReg(7'b0000000, 3'b100, 6, 5, 3);
        addWrite(4, 1, 32'd4);
        addWrite(4, 2, 32'd4);
        addWrite(4, 3, 32'd11);
        addWrite(4, 4, 32'd15);
        addWrite(4, 5, 32'd11);
        addWrite(4, 6, 32'd0);
    endtask

    task automatic runTest(input int t);
        int got;
        int waited;
        int errs;
        got    = 0;
        waited = 0;
        errs   = 0;
        @(posedge clk);
        #1;
        rstN = 1'b0;
        for (int i = 0; i < Slots; i++)
            imem[i] = prog[t][i];
        repeat (4) @(posedge clk);
        #1;
        if (imemAddr != 32'd0) begin
            $display("ERR %s reset pc: expected %h, actual %h", testName[t], 32'd0, imemAddr);
            errs++;
        end
        rstN = 1'b1;
        while (got < expCount[t] && waited < TestCycles) begin
            @(negedge clk);
            waited++;
            if (wbValid && wbDst == 5'd0 && wbData != 32'd0) begin
                $display("%s: x0 shows up on the write port with %h", testName[t], wbData);
                errs++;
            end else if (wbValid && wbDst != 5'd0) begin
                if (wbDst != expDst[t][got] || wbData != expVal[t][got]) begin
                    $display("ERR %s write %0d: expected x%0d=%h, actual x%0d=%h", testName[t],
                             got, expDst[t][got], expVal[t][got], wbDst, wbData);
                    errs++;
                end
                got++;
            end
        end
        if (got < expCount[t]) begin
            $display("%s: only %0d of %0d register writes arrived", testName[t], got,
                     expCount[t]);
            errs++;
        end
        $display("%s: %0d writes seen, %0d errors", testName[t], got, errs);
        errorCount += errs;
        if (errs != 0)
            failedTests++;
    endtask

    initial begin
        rstN        = 1'b0;
        errorCount  = 0;
        failedTests = 0;
        seed        = 32'hb433;
        for (int i = 0; i < Slots; i++)
            imem[i] = Nop;
        buildTable();
        for (int t = 0; t < NumTests; t++)
            runTest(t);
        $display("%0d tests, %0d failed, %0d errors", NumTests, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: coreTop.f
design/coreTypes.sv
design/fetchStage.sv
design/instrDecoder.sv
design/immSelect.sv
design/decodeStage.sv
design/regFile.sv
design/executeStage.sv
design/memStage.sv
design/coreTop.sv
tests/coreTopTb.sv
